// ==== verilog/dap_pkg.sv ====
package dap_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [5:0]  ap_reg_t;
    typedef logic [2:0]  size_t;
    typedef logic [2:0]  prot_t;

    // word addresses of the access-port registers.
    localparam ap_reg_t REG_CSW = 6'h00;
    localparam ap_reg_t REG_TAR = 6'h01;
    localparam ap_reg_t REG_DRW = 6'h03;
    localparam ap_reg_t REG_IDR = 6'h3f;

    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    // the size field is three bits wide starting at CSW_SIZE.
    localparam int CSW_SIZE    = 0;
    localparam int CSW_ADDRINC = 4;
    localparam int CSW_DEVEN   = 6;
    localparam int CSW_SECREQ  = 23;
    localparam int CSW_PRIV    = 29;

    localparam data_t AP_IDR_VALUE = 32'h1400_0a51;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ISSUE,
        CTRL_WAIT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        AXI_IDLE,
        AXI_ADDR,
        AXI_RESP
    } axi_state_t;

endpackage

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if import dap_pkg::*; ();

    logic  req;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    prot_t prot;

    logic  done;
    data_t rdata;
    logic  slverr;

    // one request at a time; the fields hold from req until done.
    modport ctrl (
        output req, write, addr, wdata, strb, prot,
        input  done, rdata, slverr
    );

    modport master (
        input  req, write, addr, wdata, strb, prot,
        output done, rdata, slverr
    );

endinterface

// ==== verilog/ap_regs.sv ====
`timescale 1ns/1ps

module ap_regs import dap_pkg::*; (
    input               sysclk,
    input               reset,
    input               deviceen,

    input               reg_wr_csw,
    input               reg_wr_tar,
    input  data_t       reg_wdata,
    input  ap_reg_t     reg_sel,
    input               tar_inc,
    input        [2:0]  inc_step,
    output data_t       reg_rdata,

    output size_t       csw_size,
    output logic        csw_addrinc,
    output logic        csw_secreq,
    output logic        csw_priv,
    output addr_t       tar
);

data_t csw_word;

always_ff @(posedge sysclk) begin
    if (reset) begin
        csw_size    <= SIZE_WORD;
        csw_addrinc <= 1'b0;
        csw_secreq  <= 1'b0;
        csw_priv    <= 1'b0;
        tar         <= '0;
    end else begin
        if (reg_wr_csw) begin
            csw_size    <= reg_wdata[CSW_SIZE +: 3];
            csw_addrinc <= reg_wdata[CSW_ADDRINC];
            csw_secreq  <= reg_wdata[CSW_SECREQ];
            csw_priv    <= reg_wdata[CSW_PRIV];
        end
        if (reg_wr_tar) begin
            tar <= reg_wdata;
        end else if (tar_inc) begin
            tar <= tar + addr_t'(inc_step);
        end
    end
end

// the device-enable bit is not stored, it follows the input.
always_comb begin
    csw_word                  = '0;
    csw_word[CSW_SIZE +: 3]   = csw_size;
    csw_word[CSW_ADDRINC]     = csw_addrinc;
    csw_word[CSW_DEVEN]       = deviceen;
    csw_word[CSW_SECREQ]      = csw_secreq;
    csw_word[CSW_PRIV]        = csw_priv;
end

always_comb begin
    case (reg_sel)
        REG_CSW: reg_rdata = csw_word;
        REG_TAR: reg_rdata = tar;
        REG_IDR: reg_rdata = AP_IDR_VALUE;
        default: reg_rdata = '0;
    endcase
end

endmodule

// ==== verilog/lane_steer.sv ====
`timescale 1ns/1ps

module lane_steer import dap_pkg::*; (
    input  size_t       size,
    input        [1:0]  addr_low,
    input  data_t       wdata_in,
    output logic        size_ok,
    output strb_t       strb,
    output data_t       wdata_out,
    output data_t       rmask,
    output logic [2:0]  inc_step
);

always_comb begin
    size_ok   = 1'b0;
    strb      = '0;
    wdata_out = '0;
    inc_step  = 3'd0;
    case (size)
        SIZE_BYTE: begin
            size_ok   = 1'b1;
            strb      = 4'b0001 << addr_low;
            wdata_out = {4{wdata_in[7:0]}};
            inc_step  = 3'd1;
        end
        SIZE_HALF: begin
            // a halfword must sit on an even byte address.
            size_ok   = !addr_low[0];
            strb      = addr_low[1] ? 4'b1100 : 4'b0011;
            wdata_out = {2{wdata_in[15:0]}};
            inc_step  = 3'd2;
        end
        SIZE_WORD: begin
            size_ok   = 1'b1;
            strb      = 4'b1111;
            wdata_out = wdata_in;
            inc_step  = 3'd4;
        end
        default: begin
            size_ok = 1'b0;
        end
    endcase
end

always_comb begin
    for (int i = 0; i < 4; i++) begin
        rmask[8*i +: 8] = {8{strb[i]}};
    end
end

endmodule

// ==== verilog/mem_ap_ctrl.sv ====
`timescale 1ns/1ps

module mem_ap_ctrl import dap_pkg::*; (
    input                   sysclk,
    input                   reset,

    input                   ap_upd,
    input                   ap_rnw,
    input  ap_reg_t         ap_addr,
    input  data_t           ap_wdata,
    output data_t           ap_rdata,
    output logic            ap_slverr,
    output logic            ap_busy,
    input                   deviceen,
    input                   spiden,

    output logic            reg_wr_csw,
    output logic            reg_wr_tar,
    output data_t           reg_wdata,
    output ap_reg_t         reg_sel,
    input  data_t           reg_rdata,
    output logic            tar_inc,

    input  size_t           csw_size,
    input                   csw_addrinc,
    input                   csw_secreq,
    input                   csw_priv,
    input  addr_t           tar,

    input                   size_ok,
    input  strb_t           lane_strb,
    input  data_t           lane_wdata,
    input  data_t           lane_rmask,

    mem_req_if.ctrl         mem
);

ctrl_state_t state;
logic        upd_ok;
logic        drw_sel;

// busy is only high outside the idle state, so this also drops updates during busy.
assign upd_ok  = ap_upd && !ap_busy;
assign drw_sel = (ap_addr == REG_DRW);

assign reg_sel    = ap_addr;
assign reg_wdata  = ap_wdata;
assign reg_wr_csw = upd_ok && !ap_rnw && (ap_addr == REG_CSW);
assign reg_wr_tar = upd_ok && !ap_rnw && (ap_addr == REG_TAR);

// tar moves on the same edge that drops busy.
assign tar_inc = (state == CTRL_WAIT) && mem.done && !mem.slverr && csw_addrinc;

assign mem.addr = tar;
assign mem.strb = lane_strb;

always_ff @(posedge sysclk) begin
    if (reset) begin
        state     <= CTRL_IDLE;
        ap_busy   <= 1'b0;
        ap_slverr <= 1'b0;
        ap_rdata  <= '0;
        mem.req   <= 1'b0;
    end else begin
        mem.req <= 1'b0;
        case (state)
            CTRL_IDLE: begin
                if (upd_ok && drw_sel) begin
                    ap_busy   <= 1'b1;
                    mem.write <= !ap_rnw;
                    mem.wdata <= lane_wdata;
                    state     <= CTRL_ISSUE;
                end else if (upd_ok) begin
                    ap_slverr <= 1'b0;
                    if (ap_rnw) begin
                        ap_rdata <= reg_rdata;
                    end
                end
            end
            CTRL_ISSUE: begin
                if (!deviceen || !size_ok) begin
                    ap_busy   <= 1'b0;
                    ap_slverr <= 1'b1;
                    state     <= CTRL_IDLE;
                end else begin
                    mem.req  <= 1'b1;
                    mem.prot <= {1'b0, !(csw_secreq && spiden), csw_priv};
                    state    <= CTRL_WAIT;
                end
            end
            CTRL_WAIT: begin
                if (mem.done) begin
                    ap_busy   <= 1'b0;
                    ap_slverr <= mem.slverr;
                    if (!mem.write) begin
                        ap_rdata <= mem.rdata & lane_rmask;
                    end
                    state <= CTRL_IDLE;
                end
            end
            default: begin
                state <= CTRL_IDLE;
            end
        endcase
    end
end

endmodule

// ==== verilog/axi_master.sv ====
`timescale 1ns/1ps

module axi_master import dap_pkg::*; (
    input                   sysclk,
    input                   reset,

    mem_req_if.master       mp,

    output logic            awvalid,
    input                   awready,
    output addr_t           awaddr,
    output prot_t           awprot,
    output logic            wvalid,
    input                   wready,
    output data_t           wdata,
    output strb_t           wstrb,
    input                   bvalid,
    output logic            bready,
    input        [1:0]      bresp,
    output logic            arvalid,
    input                   arready,
    output addr_t           araddr,
    output prot_t           arprot,
    input                   rvalid,
    output logic            rready,
    input  data_t           rdata,
    input        [1:0]      rresp
);

axi_state_t state;
logic       aw_hold;
logic       w_hold;
logic       ar_hold;

// request fields stay stable until done, so the payload is taken straight from them.
assign awaddr = mp.addr;
assign awprot = mp.prot;
assign wdata  = mp.wdata;
assign wstrb  = mp.strb;
assign araddr = mp.addr;
assign arprot = mp.prot;

assign aw_hold = awvalid && !awready;
assign w_hold  = wvalid && !wready;
assign ar_hold = arvalid && !arready;

always_ff @(posedge sysclk) begin
    if (reset) begin
        state   <= AXI_IDLE;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        bready  <= 1'b0;
        rready  <= 1'b0;
        mp.done <= 1'b0;
    end else begin
        mp.done <= 1'b0;
        case (state)
            AXI_IDLE: begin
                if (mp.req) begin
                    awvalid <= mp.write;
                    wvalid  <= mp.write;
                    arvalid <= !mp.write;
                    state   <= AXI_ADDR;
                end
            end
            AXI_ADDR: begin
                awvalid <= aw_hold;
                wvalid  <= w_hold;
                arvalid <= ar_hold;
                if (!aw_hold && !w_hold && !ar_hold) begin
                    bready <= mp.write;
                    rready <= !mp.write;
                    state  <= AXI_RESP;
                end
            end
            AXI_RESP: begin
                if (bready && bvalid) begin
                    bready    <= 1'b0;
                    mp.done   <= 1'b1;
                    mp.slverr <= |bresp;
                    state     <= AXI_IDLE;
                end
                if (rready && rvalid) begin
                    rready    <= 1'b0;
                    mp.done   <= 1'b1;
                    mp.slverr <= |rresp;
                    mp.rdata  <= rdata;
                    state     <= AXI_IDLE;
                end
            end
            default: begin
                state <= AXI_IDLE;
            end
        endcase
    end
end

endmodule

// ==== verilog/mem_ap.sv ====
`timescale 1ns/1ps

module mem_ap import dap_pkg::*; (
    input               sysclk,
    input               reset,

    input               ap_upd,
    input  data_t       ap_wdata,
    input  ap_reg_t     ap_addr,
    input               ap_rnw,
    output data_t       ap_rdata,
    output logic        ap_slverr,
    output logic        ap_busy,

    input               spiden,
    input               deviceen,

    output logic        awvalid,
    input               awready,
    output addr_t       awaddr,
    output prot_t       awprot,
    output logic        wvalid,
    input               wready,
    output data_t       wdata,
    output strb_t       wstrb,
    input               bvalid,
    output logic        bready,
    input        [1:0]  bresp,
    output logic        arvalid,
    input               arready,
    output addr_t       araddr,
    output prot_t       arprot,
    input               rvalid,
    output logic        rready,
    input  data_t       rdata,
    input        [1:0]  rresp
);

logic       reg_wr_csw;
logic       reg_wr_tar;
data_t      reg_wdata;
ap_reg_t    reg_sel;
data_t      reg_rdata;
logic       tar_inc;
logic [2:0] inc_step;
size_t      csw_size;
logic       csw_addrinc;
logic       csw_secreq;
logic       csw_priv;
addr_t      tar;
logic       size_ok;
strb_t      lane_strb;
data_t      lane_wdata;
data_t      lane_rmask;

mem_req_if u_mem_req ();

mem_ap_ctrl u_ctrl (
    .sysclk      ( sysclk      ),
    .reset       ( reset       ),
    .ap_upd      ( ap_upd      ),
    .ap_rnw      ( ap_rnw      ),
    .ap_addr     ( ap_addr     ),
    .ap_wdata    ( ap_wdata    ),
    .ap_rdata    ( ap_rdata    ),
    .ap_slverr   ( ap_slverr   ),
    .ap_busy     ( ap_busy     ),
    .deviceen    ( deviceen    ),
    .spiden      ( spiden      ),
    .reg_wr_csw  ( reg_wr_csw  ),
    .reg_wr_tar  ( reg_wr_tar  ),
    .reg_wdata   ( reg_wdata   ),
    .reg_sel     ( reg_sel     ),
    .reg_rdata   ( reg_rdata   ),
    .tar_inc     ( tar_inc     ),
    .csw_size    ( csw_size    ),
    .csw_addrinc ( csw_addrinc ),
    .csw_secreq  ( csw_secreq  ),
    .csw_priv    ( csw_priv    ),
    .tar         ( tar         ),
    .size_ok     ( size_ok     ),
    .lane_strb   ( lane_strb   ),
    .lane_wdata  ( lane_wdata  ),
    .lane_rmask  ( lane_rmask  ),
    .mem         ( u_mem_req   )
);

ap_regs u_regs (
    .sysclk      ( sysclk      ),
    .reset       ( reset       ),
    .deviceen    ( deviceen    ),
    .reg_wr_csw  ( reg_wr_csw  ),
    .reg_wr_tar  ( reg_wr_tar  ),
    .reg_wdata   ( reg_wdata   ),
    .reg_sel     ( reg_sel     ),
    .tar_inc     ( tar_inc     ),
    .inc_step    ( inc_step    ),
    .reg_rdata   ( reg_rdata   ),
    .csw_size    ( csw_size    ),
    .csw_addrinc ( csw_addrinc ),
    .csw_secreq  ( csw_secreq  ),
    .csw_priv    ( csw_priv    ),
    .tar         ( tar         )
);

// lanes follow the current size and the low address bits of tar.
lane_steer u_lanes (
    .size        ( csw_size    ),
    .addr_low    ( tar[1:0]    ),
    .wdata_in    ( ap_wdata    ),
    .size_ok     ( size_ok     ),
    .strb        ( lane_strb   ),
    .wdata_out   ( lane_wdata  ),
    .rmask       ( lane_rmask  ),
    .inc_step    ( inc_step    )
);

axi_master u_axi (
    .sysclk      ( sysclk      ),
    .reset       ( reset       ),
    .mp          ( u_mem_req   ),
    .awvalid     ( awvalid     ),
    .awready     ( awready     ),
    .awaddr      ( awaddr      ),
    .awprot      ( awprot      ),
    .wvalid      ( wvalid      ),
    .wready      ( wready      ),
    .wdata       ( wdata       ),
    .wstrb       ( wstrb       ),
    .bvalid      ( bvalid      ),
    .bready      ( bready      ),
    .bresp       ( bresp       ),
    .arvalid     ( arvalid     ),
    .arready     ( arready     ),
    .araddr      ( araddr      ),
    .arprot      ( arprot      ),
    .rvalid      ( rvalid      ),
    .rready      ( rready      ),
    .rdata       ( rdata       ),
    .rresp       ( rresp       )
);

endmodule

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input               sysclk,
    input               awvalid,
    output logic        awready,
    input        [31:0] awaddr,
    input               wvalid,
    output logic        wready,
    input        [31:0] wdata,
    input        [3:0]  wstrb,
    output logic        bvalid,
    input               bready,
    output logic [1:0]  bresp,
    input               arvalid,
    output logic        arready,
    input        [31:0] araddr,
    output logic        rvalid,
    input               rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

// this word answers every access with SLVERR.
localparam logic [31:0] ERR_ADDR = 32'h0000_03f0;

logic [31:0] mem [256];

task automatic idle_cycles();
    repeat ($urandom_range(3)) begin
        @(posedge sysclk);
        #1;
    end
endtask

task automatic serve_write();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    idle_cycles();
    addr    = awaddr;
    data    = wdata;
    strb    = wstrb;
    awready = 1'b1;
    wready  = 1'b1;
    @(posedge sysclk);
    #1;
    awready = 1'b0;
    wready  = 1'b0;
    bresp   = (addr[31:2] == ERR_ADDR[31:2]) ? 2'b10 : 2'b00;
    if (bresp == 2'b00) begin
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                mem[addr[9:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    end
    idle_cycles();
    bvalid = 1'b1;
    while (!bready) begin
        @(posedge sysclk);
        #1;
    end
    @(posedge sysclk);
    #1;
    bvalid = 1'b0;
endtask

task automatic serve_read();
    logic [31:0] addr;
    idle_cycles();
    addr    = araddr;
    arready = 1'b1;
    @(posedge sysclk);
    #1;
    arready = 1'b0;
    idle_cycles();
    rresp  = (addr[31:2] == ERR_ADDR[31:2]) ? 2'b10 : 2'b00;
    rdata  = (rresp == 2'b00) ? mem[addr[9:2]] : 32'h0;
    rvalid = 1'b1;
    while (!rready) begin
        @(posedge sysclk);
        #1;
    end
    @(posedge sysclk);
    #1;
    rvalid = 1'b0;
endtask

initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = 2'b00;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = 32'h0;
    rresp   = 2'b00;
    for (int i = 0; i < 256; i++) begin
        mem[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0409);
    end
    forever begin
        @(posedge sysclk);
        #1;
        if (awvalid && wvalid) begin
            serve_write();
        end else if (arvalid) begin
            serve_read();
        end
    end
end

endmodule

// ==== dv/tb_mem_ap.sv ====
`timescale 1ns/1ps

module tb_mem_ap import dap_pkg::*; ();

localparam int MAX_CYCLES = 20000;
localparam data_t CSW_WMASK = 32'h2080_0017;

logic        sysclk;
logic        reset;
logic        ap_upd;
data_t       ap_wdata;
ap_reg_t     ap_addr;
logic        ap_rnw;
data_t       ap_rdata;
logic        ap_slverr;
logic        ap_busy;
logic        spiden;
logic        deviceen;
logic        awvalid;
logic        awready;
addr_t       awaddr;
prot_t       awprot;
logic        wvalid;
logic        wready;
data_t       wdata;
strb_t       wstrb;
logic        bvalid;
logic        bready;
logic [1:0]  bresp;
logic        arvalid;
logic        arready;
addr_t       araddr;
prot_t       arprot;
logic        rvalid;
logic        rready;
data_t       rdata;
logic [1:0]  rresp;

// reference state of the access port and of the bus memory.
data_t       ref_csw;
addr_t       ref_tar;
data_t       ref_mem [256];
data_t       exp_rdata;
logic        exp_slverr;
logic        exp_bus;
logic        exp_write;
addr_t       exp_addr;
prot_t       exp_prot;
strb_t       exp_strb;
data_t       exp_wdata;
int          cycle_count = 0;
event        result_ready;

mem_ap i_mem_ap (.*);

axi_mem_model i_axi_mem (.*);

initial begin
    sysclk = 1'b0;
    forever #2 sysclk = ~sysclk;
end

always @(posedge sysclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
        $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timed out");
    end
end

task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    $display("TEST RESULT: FAIL");
    $fatal(1, "value mismatch");
endtask

task automatic report_failure(input string what);
    $display("Error at %0d ns: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "protocol error");
endtask

// applies one access to the reference state and sets the expected results.
function automatic void predict_access(input ap_reg_t a, input logic rnw, input data_t wd);
    logic       ok;
    strb_t      strb;
    data_t      rep;
    data_t      mask;
    logic [2:0] step;
    logic       err;
    logic [7:0] idx;
    ok         = 1'b0;
    strb       = '0;
    rep        = '0;
    step       = 3'd0;
    exp_bus    = 1'b0;
    exp_slverr = 1'b0;
    if (a != REG_DRW) begin
        if (!rnw && a == REG_CSW) begin
            ref_csw = wd & CSW_WMASK;
        end else if (!rnw && a == REG_TAR) begin
            ref_tar = wd;
        end else if (rnw) begin
            case (a)
                REG_CSW: exp_rdata = ref_csw | (data_t'(deviceen) << 6);
                REG_TAR: exp_rdata = ref_tar;
                REG_IDR: exp_rdata = AP_IDR_VALUE;
                default: exp_rdata = '0;
            endcase
        end
        return;
    end
    case (ref_csw[2:0])
        3'd0: begin
            ok   = 1'b1;
            strb = 4'b0001 << ref_tar[1:0];
            rep  = {4{wd[7:0]}};
            step = 3'd1;
        end
        3'd1: begin
            ok   = !ref_tar[0];
            strb = ref_tar[1] ? 4'b1100 : 4'b0011;
            rep  = {2{wd[15:0]}};
            step = 3'd2;
        end
        3'd2: begin
            ok   = 1'b1;
            strb = 4'b1111;
            rep  = wd;
            step = 3'd4;
        end
        default: begin
            ok = 1'b0;
        end
    endcase
    if (!deviceen || !ok) begin
        exp_slverr = 1'b1;
        return;
    end
    for (int i = 0; i < 4; i++) begin
        mask[8*i +: 8] = {8{strb[i]}};
    end
    exp_bus    = 1'b1;
    exp_write  = !rnw;
    exp_addr   = ref_tar;
    exp_prot   = {1'b0, !(ref_csw[23] && spiden), ref_csw[29]};
    exp_strb   = strb;
    exp_wdata  = rep;
    err        = (ref_tar[31:2] == 30'h0fc);
    idx        = ref_tar[9:2];
    exp_slverr = err;
    if (rnw) begin
        exp_rdata = (err ? '0 : ref_mem[idx]) & mask;
    end else if (!err) begin
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                ref_mem[idx][8*i +: 8] = rep[8*i +: 8];
            end
        end
    end
    if (!err && ref_csw[4]) begin
        ref_tar = ref_tar + addr_t'(step);
    end
endfunction

always @(result_ready) begin
    assert (ap_rdata == exp_rdata)
        else report_mismatch("ap_rdata", ap_rdata, exp_rdata);
    assert (ap_slverr == exp_slverr)
        else report_mismatch("ap_slverr", 32'(ap_slverr), 32'(exp_slverr));
end

always @(negedge sysclk) begin
    if (awvalid || wvalid || arvalid || bready || rready) begin
        assert (exp_bus) else report_failure("AXI valid raised for a refused access");
    end
    if (awvalid && awready) begin
        assert (exp_write) else report_failure("AXI write issued for a read access");
        assert (wvalid) else report_failure("write data not presented with the write address");
        assert (awaddr == exp_addr) else report_mismatch("awaddr", awaddr, exp_addr);
        assert (awprot == exp_prot) else report_mismatch("awprot", 32'(awprot), 32'(exp_prot));
        assert (wstrb == exp_strb) else report_mismatch("wstrb", 32'(wstrb), 32'(exp_strb));
        assert (wdata == exp_wdata) else report_mismatch("wdata", wdata, exp_wdata);
    end
    if (arvalid && arready) begin
        assert (!exp_write) else report_failure("AXI read issued for a write access");
        assert (araddr == exp_addr) else report_mismatch("araddr", araddr, exp_addr);
        assert (arprot == exp_prot) else report_mismatch("arprot", 32'(arprot), 32'(exp_prot));
    end
end

// called 1 ns after a rising edge; returns at the same point of a later cycle.
task automatic run_access(input ap_reg_t a, input logic rnw, input data_t wd);
    int busy_cycles;
    predict_access(a, rnw, wd);
    busy_cycles = 0;
    ap_addr  = a;
    ap_rnw   = rnw;
    ap_wdata = wd;
    ap_upd   = 1'b1;
    @(posedge sysclk);
    #1;
    ap_upd = 1'b0;
    assert (ap_busy == (a == REG_DRW))
        else report_mismatch("ap_busy", 32'(ap_busy), 32'(a == REG_DRW));
    while (ap_busy) begin
        busy_cycles++;
        @(posedge sysclk);
        #1;
    end
    if (a == REG_DRW && !exp_bus) begin
        assert (busy_cycles == 1)
            else report_failure("busy did not last exactly one cycle for a refused access");
    end
    -> result_ready;
    @(posedge sysclk);
    #1;
endtask

task automatic write_reg(input ap_reg_t a, input data_t wd);
    run_access(a, 1'b0, wd);
endtask

task automatic read_reg(input ap_reg_t a);
    run_access(a, 1'b1, 32'h0);
endtask

initial begin
    addr_t addr;
    void'($urandom(32'h1502_bb43));
    reset      = 1'b1;
    ap_upd     = 1'b0;
    ap_wdata   = '0;
    ap_addr    = '0;
    ap_rnw     = 1'b1;
    spiden     = 1'b0;
    deviceen   = 1'b1;
    ref_csw    = 32'h0000_0002;
    ref_tar    = '0;
    exp_rdata  = '0;
    exp_slverr = 1'b0;
    exp_bus    = 1'b0;
    exp_write  = 1'b0;
    for (int i = 0; i < 256; i++) begin
        ref_mem[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0409);
    end
    repeat (10) @(posedge sysclk);
    #1;
    reset = 1'b0;

    read_reg(REG_CSW);
    read_reg(REG_TAR);
    read_reg(REG_IDR);
    read_reg(6'h02);
    write_reg(REG_CSW, 32'hffff_ffff);
    read_reg(REG_CSW);
    deviceen = 1'b0;
    read_reg(REG_CSW);
    deviceen = 1'b1;
    write_reg(REG_TAR, 32'h1234_5678);
    read_reg(REG_TAR);
    write_reg(REG_IDR, 32'h0);
    read_reg(REG_IDR);

    // word traffic with auto-increment, kept below the error word.
    write_reg(REG_CSW, 32'h0000_0012);
    for (int n = 0; n < 16; n++) begin
        addr = {22'd0, 8'($urandom_range(250)), 2'b00};
        write_reg(REG_TAR, addr);
        write_reg(REG_DRW, $urandom());
        read_reg(REG_TAR);
        write_reg(REG_TAR, addr);
        read_reg(REG_DRW);
        read_reg(REG_DRW);
    end

    for (int sz = 0; sz < 2; sz++) begin
        for (int lo = 0; lo < 4; lo++) begin
            write_reg(REG_CSW, 32'(sz));
            write_reg(REG_TAR, 32'h0000_0100 + 32'(lo));
            write_reg(REG_DRW, $urandom());
            read_reg(REG_DRW);
            write_reg(REG_CSW, 32'h0000_0002);
            write_reg(REG_TAR, 32'h0000_0100);
            read_reg(REG_DRW);
        end
    end
    write_reg(REG_CSW, 32'h0000_0003);
    read_reg(REG_DRW);

    write_reg(REG_CSW, 32'h0000_0012);
    write_reg(REG_TAR, 32'h0000_0040);
    deviceen = 1'b0;
    write_reg(REG_DRW, 32'hdead_beef);
    read_reg(REG_DRW);
    read_reg(REG_TAR);
    deviceen = 1'b1;
    write_reg(REG_DRW, 32'hdead_beef);
    read_reg(REG_TAR);

    for (int k = 0; k < 8; k++) begin
        spiden = k[0];
        write_reg(REG_CSW, 32'h2 | (32'(k[2]) << 23) | (32'(k[1]) << 29));
        write_reg(REG_TAR, 32'h0000_0080);
        write_reg(REG_DRW, $urandom());
        read_reg(REG_DRW);
    end

    write_reg(REG_CSW, 32'h0000_0012);
    write_reg(REG_TAR, 32'h0000_03f0);
    write_reg(REG_DRW, 32'h0000_0001);
    read_reg(REG_TAR);
    read_reg(REG_DRW);
    write_reg(REG_TAR, 32'h0000_0010);
    read_reg(REG_DRW);

    $display("TEST RESULT: PASS");
    $finish;
end

endmodule

// ==== project.f ====
verilog/dap_pkg.sv
verilog/mem_req_if.sv
verilog/ap_regs.sv
verilog/lane_steer.sv
verilog/mem_ap_ctrl.sv
verilog/axi_master.sv
verilog/mem_ap.sv
dv/axi_mem_model.sv
dv/tb_mem_ap.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f project.f \
    --top-module tb_mem_ap \
    -o tb_mem_ap

./obj_dir/tb_mem_ap
